/* compile.f */
+incdir+hw
hw/vread_pkg.sv
hw/vread_ctrl.sv
hw/ext_fetch.sv
hw/flow_addrgen.sv
hw/dual_port_mem.sv
hw/vread_top.sv
tb/ext_mem_model.sv
tb/tb_vread.sv

/* run_sim.sh */
#!/bin/sh
# build and run the vector read testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_vread -f compile.f -o simv
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "sim failed" sim.log; then
   exit 1
fi
if ! grep -q "sim passed" sim.log; then
   echo "simulation ended without a verdict"
   exit 1
fi
exit 0

/* tb/tb_vread.sv */
`timescale 1ns/1ps

`include "vread_macros.svh"

module tb_vread;

   localparam int numTests = 12;
   localparam int memDepth = 2 ** `VREAD_MEM_ADDR_W;

   logic                     clk;
   logic                     rst;
   logic                     run;
   vread_pkg::fetchCfg_t     fetchCfg;
   vread_pkg::streamCfg_t    streamCfg;
   vread_pkg::busReq_t       busReq;
   vread_pkg::busRsp_t       busRsp;
   logic [`VREAD_DATA_W-1:0] flowOut;
   logic                     flowValid;
   logic                     busy;
   logic                     done;

   vread_pkg::fetchCfg_t     fetchCfgs [numTests];
   vread_pkg::streamCfg_t    streamCfgs [numTests];
   logic [`VREAD_DATA_W-1:0] shadowMem [memDepth];
   logic [`VREAD_DATA_W-1:0] expWords [memDepth];
   int                       expCnt;
   int                       expFlows;
   int                       expSize;
   int                       beatCnt;
   int                       flowCnt;
   int                       runsAccepted;
   int                       donesSeen;
   int                       mismatchCnt;
   int                       otherCnt;
   int                       limitCycles;

   vread_top i_dut (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .fetchCfg  (fetchCfg),
      .streamCfg (streamCfg),
      .busRsp    (busRsp),
      .busReq    (busReq),
      .flowOut   (flowOut),
      .flowValid (flowValid),
      .busy      (busy),
      .done      (done)
   );

   ext_mem_model i_extMem (
      .clk    (clk),
      .busReq (busReq),
      .busRsp (busRsp)
   );

   always #4 clk = ~clk;

   // per run progress, cleared when a run is accepted
   always @(posedge clk)
   begin
      if (rst)
      begin
         beatCnt      <= 0;
         flowCnt      <= 0;
         runsAccepted <= 0;
         donesSeen    <= 0;
      end
      else
      begin
         if (run && !busy)
         begin
            beatCnt      <= 0;
            flowCnt      <= 0;
            runsAccepted <= runsAccepted + 1;
         end
         else
         begin
            if (busReq.valid && busRsp.ready)
            begin
               beatCnt <= beatCnt + 1;
            end
            if (flowValid)
            begin
               flowCnt <= flowCnt + 1;
            end
         end
         if (done)
         begin
            donesSeen <= donesSeen + 1;
         end
      end
   end

   reqHold: assert property (@(posedge clk) disable iff (rst)
      busReq.valid && !busRsp.ready |=> busReq.valid && $stable(busReq.addr))
      else
      begin
         otherCnt++;
         $display("bus request was dropped or moved before ready at %0t", $time);
      end

   beatAddr: assert property (@(posedge clk) disable iff (rst)
      busReq.valid && busRsp.ready |-> busReq.addr == fetchCfg.extAddr + 32'(beatCnt))
      else
      begin
         mismatchCnt++;
         $display("mismatch at %0t: accepted beat has the wrong address", $time);
      end

   beatTotal: assert property (@(posedge clk) disable iff (rst)
      done |-> beatCnt == expSize)
      else
      begin
         mismatchCnt++;
         $display("mismatch at %0t: beat count differs from the fetch size", $time);
      end

   flowData: assert property (@(posedge clk) disable iff (rst)
      flowValid |-> flowCnt < expCnt && flowOut == expWords[flowCnt])
      else
      begin
         mismatchCnt++;
         $display("mismatch at %0t: flow word differs from the reference", $time);
      end

   flowTotal: assert property (@(posedge clk) disable iff (rst)
      done |-> flowCnt == expFlows)
      else
      begin
         mismatchCnt++;
         $display("mismatch at %0t: flow word count differs from iter times duty", $time);
      end

   busyAfterRun: assert property (@(posedge clk) disable iff (rst)
      run && !busy |=> busy)
      else
      begin
         otherCnt++;
         $display("busy did not rise after run at %0t", $time);
      end

   // done comes exactly in the cycle where busy drops
   doneEndsBusy: assert property (@(posedge clk) disable iff (rst)
      done == $fell(busy))
      else
      begin
         otherCnt++;
         $display("busy and done are out of step at %0t", $time);
      end

   oneDonePerRun: assert property (@(posedge clk) disable iff (rst)
      done |-> runsAccepted == donesSeen + 1)
      else
      begin
         otherCnt++;
         $display("done count does not match the accepted runs at %0t", $time);
      end

   resetQuiet: assert property (@(posedge clk)
      $fell(rst) |-> !busy && !done && !flowValid && !busReq.valid
                     && !i_dut.fetchStart && !i_dut.streamStart)
      else
      begin
         otherCnt++;
         $display("control outputs not low after reset at %0t", $time);
      end

   task automatic makeConfigs();
      for (int t = 0; t < numTests; t++)
      begin
         fetchCfgs[t].extAddr  = $urandom;
         fetchCfgs[t].intAddr  = 8'($urandom);
         fetchCfgs[t].size     = 9'(1 + $urandom % 256);
         streamCfgs[t].start   = 8'($urandom);
         streamCfgs[t].iter    = 8'(1 + $urandom % 6);
         streamCfgs[t].per     = 6'(1 + $urandom % 12);
         streamCfgs[t].duty    = 6'($urandom % 14);
         streamCfgs[t].incr    = 8'($urandom);
         streamCfgs[t].shift   = 8'($urandom);
         streamCfgs[t].reverse = 1'($urandom);
      end
      // first run fills the whole internal memory
      fetchCfgs[0].intAddr = '0;
      fetchCfgs[0].size    = 9'd256;
      // stream only, from words already held
      fetchCfgs[3].size = '0;
      // fetch only
      streamCfgs[5].iter = '0;
      // neither phase
      fetchCfgs[8].size = '0;
      streamCfgs[8].per = '0;
      streamCfgs[10].duty    = streamCfgs[10].per;
      streamCfgs[10].reverse = 1'b1;
   endtask

   task automatic prepareRun(input vread_pkg::fetchCfg_t f, input vread_pkg::streamCfg_t s);
      logic [`VREAD_MEM_ADDR_W-1:0] raw;
      logic [`VREAD_MEM_ADDR_W-1:0] addr;
      int                           dutySlots;
      // fetch lands before the stream reads
      for (int i = 0; i < int'(f.size); i++)
      begin
         shadowMem[8'(int'(f.intAddr) + i)] = i_extMem.wordAt(f.extAddr + 32'(i));
      end
      expCnt = 0;
      for (int k = 0; k < int'(s.iter); k++)
      begin
         for (int j = 0; j < int'(s.duty) && j < int'(s.per); j++)
         begin
            raw = 8'(int'(s.start) + k * int'(s.shift) + j * int'(s.incr));
            for (int b = 0; b < `VREAD_MEM_ADDR_W; b++)
            begin
               addr[b] = s.reverse ? raw[`VREAD_MEM_ADDR_W-1-b] : raw[b];
            end
            expWords[expCnt] = shadowMem[addr];
            expCnt++;
         end
      end
      dutySlots = (s.duty < s.per) ? int'(s.duty) : int'(s.per);
      expFlows  = int'(s.iter) * dutySlots;
      expSize   = int'(f.size);
   endtask

   task automatic doRun(input int t, input bit pokeWhileBusy);
      prepareRun(fetchCfgs[t], streamCfgs[t]);
      @(negedge clk);
      fetchCfg  = fetchCfgs[t];
      streamCfg = streamCfgs[t];
      run       = 1'b1;
      @(negedge clk);
      run = 1'b0;
      if (pokeWhileBusy)
      begin
         repeat (2) @(negedge clk);
         // second request only while busy, so it must be dropped
         run = busy;
         @(negedge clk);
         run = 1'b0;
      end
      while (donesSeen != t + 1)
      begin
         @(negedge clk);
      end
      repeat (3) @(negedge clk);
   endtask

   initial
   begin
      void'($urandom(32'h1635946f));
      clk         = 1'b0;
      rst         = 1'b1;
      run         = 1'b0;
      fetchCfg    = '0;
      streamCfg   = '0;
      mismatchCnt = 0;
      otherCnt    = 0;
      makeConfigs();
      limitCycles = 10;
      for (int t = 0; t < numTests; t++)
      begin
         limitCycles += int'(fetchCfgs[t].size) * 8
                        + int'(streamCfgs[t].iter) * int'(streamCfgs[t].per) + 50;
      end
      fork
         begin
            repeat (limitCycles) @(posedge clk);
            $display("watchdog expired after %0d cycles with runs still pending", limitCycles);
            $display("sim failed");
            $finish;
         end
      join_none
      repeat (10) @(negedge clk);
      rst = 1'b0;
      for (int t = 0; t < numTests; t++)
      begin
         doRun(t, (t % 3) == 1);
      end
      repeat (5) @(negedge clk);
      $display("errors: %0d value mismatches, %0d other failures", mismatchCnt, otherCnt);
      if (mismatchCnt == 0 && otherCnt == 0)
      begin
         $display("sim passed");
      end
      else
      begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

/* tb/ext_mem_model.sv */
`timescale 1ns/1ps

`include "vread_macros.svh"

module ext_mem_model (
   input  logic               clk,
   input  vread_pkg::busReq_t busReq,
   output vread_pkg::busRsp_t busRsp
);

   // fixed word per address, every address bit matters
   function automatic logic [`VREAD_DATA_W-1:0] wordAt(
      input logic [`VREAD_IO_ADDR_W-1:0] addr
   );
      logic [`VREAD_DATA_W-1:0] mixed;
      mixed = addr * 32'h9e3779b1;
      return mixed ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a0f0f;
   endfunction

   initial
   begin
      busRsp = '0;
   end

   // ready high on roughly six cycles out of ten
   always @(negedge clk)
   begin
      busRsp.ready <= (($urandom % 10) < 6);
      busRsp.rdata <= wordAt(busReq.addr);
   end

endmodule

/* hw/vread_top.sv */
`timescale 1ns/1ps

`include "vread_macros.svh"

module vread_top (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run,
   input  vread_pkg::fetchCfg_t     fetchCfg,
   input  vread_pkg::streamCfg_t    streamCfg,
   input  vread_pkg::busRsp_t       busRsp,
   output vread_pkg::busReq_t       busReq,
   output logic [`VREAD_DATA_W-1:0] flowOut,
   output logic                     flowValid,
   output logic                     busy,
   output logic                     done
);

   logic              fetchStart;
   logic              streamStart;
   logic              fetchDone;
   logic              streamDone;
   logic              streamEmpty;
   vread_pkg::memWr_t memWr;
   vread_pkg::memRd_t memRd;

   // no slots at all when either loop count is zero
   assign streamEmpty = (streamCfg.iter == '0) || (streamCfg.per == '0);

   vread_ctrl i_ctrl (
      .clk         (clk),
      .rst         (rst),
      .run         (run),
      .fetchSize   (fetchCfg.size),
      .streamEmpty (streamEmpty),
      .fetchDone   (fetchDone),
      .streamDone  (streamDone),
      .fetchStart  (fetchStart),
      .streamStart (streamStart),
      .busy        (busy),
      .done        (done)
   );

   ext_fetch i_fetch (
      .clk    (clk),
      .rst    (rst),
      .start  (fetchStart),
      .cfg    (fetchCfg),
      .busRsp (busRsp),
      .busReq (busReq),
      .memWr  (memWr),
      .done   (fetchDone)
   );

   flow_addrgen i_addrgen (
      .clk   (clk),
      .rst   (rst),
      .start (streamStart),
      .cfg   (streamCfg),
      .memRd (memRd),
      .done  (streamDone)
   );

   dual_port_mem i_mem (
      .clk     (clk),
      .wr      (memWr),
      .rd      (memRd),
      .rdData  (flowOut),
      .rdValid (flowValid)
   );

endmodule

/* hw/dual_port_mem.sv */
`timescale 1ns/1ps

`include "vread_macros.svh"

module dual_port_mem (
   input  logic                     clk,
   input  vread_pkg::memWr_t        wr,
   input  vread_pkg::memRd_t        rd,
   output logic [`VREAD_DATA_W-1:0] rdData,
   output logic                     rdValid
);

   localparam int memDepth = 2 ** `VREAD_MEM_ADDR_W;

   logic [`VREAD_DATA_W-1:0] mem [0:memDepth-1];

   always_ff @(posedge clk)
   begin
      if (wr.en)
      begin
         mem[wr.addr] <= wr.data;
      end
   end

   // read data and its strobe land together one cycle later
   always_ff @(posedge clk)
   begin
      if (rd.en)
      begin
         rdData <= mem[rd.addr];
      end
      rdValid <= rd.en;
   end

endmodule

/* hw/flow_addrgen.sv */
`timescale 1ns/1ps

`include "vread_macros.svh"

module flow_addrgen (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  start,
   input  vread_pkg::streamCfg_t cfg,
   output vread_pkg::memRd_t     memRd,
   output logic                  done
);

   logic                         active;
   logic [`VREAD_PERIOD_W-1:0]   inner;
   logic [`VREAD_MEM_ADDR_W-1:0] outer;
   logic [`VREAD_MEM_ADDR_W-1:0] baseAddr;
   logic [`VREAD_MEM_ADDR_W-1:0] curAddr;
   logic                         lastInner;
   logic                         lastOuter;

   function automatic logic [`VREAD_MEM_ADDR_W-1:0] reverseBits(
      input logic [`VREAD_MEM_ADDR_W-1:0] word
   );
      logic [`VREAD_MEM_ADDR_W-1:0] res;
      for (int i = 0; i < `VREAD_MEM_ADDR_W; i++)
      begin
         res[i] = word[`VREAD_MEM_ADDR_W-1-i];
      end
      return res;
   endfunction

   assign lastInner = (inner == cfg.per - `VREAD_PERIOD_W'd1);
   assign lastOuter = (outer == cfg.iter - `VREAD_MEM_ADDR_W'd1);
   assign done      = active & lastInner & lastOuter;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         active   <= 1'b0;
         inner    <= '0;
         outer    <= '0;
         baseAddr <= '0;
         curAddr  <= '0;
      end
      else if (start)
      begin
         active   <= 1'b1;
         inner    <= '0;
         outer    <= '0;
         baseAddr <= cfg.start;
         curAddr  <= cfg.start;
      end
      else if (active)
      begin
         if (lastInner)
         begin
            // next period starts one shift further on
            inner    <= '0;
            outer    <= outer + `VREAD_MEM_ADDR_W'd1;
            baseAddr <= baseAddr + cfg.shift;
            curAddr  <= baseAddr + cfg.shift;
            if (lastOuter)
            begin
               active <= 1'b0;
            end
         end
         else
         begin
            inner   <= inner + `VREAD_PERIOD_W'd1;
            curAddr <= curAddr + cfg.incr;
         end
      end
   end

   // slots past duty stay idle
   always_comb
   begin
      memRd.en   = active & (inner < cfg.duty);
      memRd.addr = cfg.reverse ? reverseBits(curAddr) : curAddr;
   end

   startWhenIdle: assert property (@(posedge clk) disable iff (rst)
      start |-> !active)
      else $error("stream start while the generator is running");

endmodule

/* hw/ext_fetch.sv */
`timescale 1ns/1ps

`include "vread_macros.svh"

module ext_fetch (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 start,
   input  vread_pkg::fetchCfg_t cfg,
   input  vread_pkg::busRsp_t   busRsp,
   output vread_pkg::busReq_t   busReq,
   output vread_pkg::memWr_t    memWr,
   output logic                 done
);

   logic                        active;
   logic [`VREAD_SIZE_W-1:0]    beatCnt;
   logic [`VREAD_IO_ADDR_W-1:0] extAddr;
   logic                        beat;
   logic                        lastBeat;

   // a beat completes on any ready cycle of an open request
   assign beat     = active & busRsp.ready;
   assign lastBeat = (beatCnt == cfg.size - `VREAD_SIZE_W'd1);
   assign done     = beat & lastBeat;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         active  <= 1'b0;
         beatCnt <= '0;
         extAddr <= '0;
      end
      else if (start)
      begin
         active  <= 1'b1;
         beatCnt <= '0;
         extAddr <= cfg.extAddr;
      end
      else if (beat)
      begin
         beatCnt <= beatCnt + `VREAD_SIZE_W'd1;
         extAddr <= extAddr + `VREAD_IO_ADDR_W'd1;
         if (lastBeat)
         begin
            active <= 1'b0;
         end
      end
   end

   always_comb
   begin
      busReq.valid = active;
      busReq.addr  = extAddr;
   end

   // internal address wraps around the memory
   always_comb
   begin
      memWr.en   = beat;
      memWr.addr = cfg.intAddr + beatCnt[`VREAD_MEM_ADDR_W-1:0];
      memWr.data = busRsp.rdata;
   end

   reqStable: assert property (@(posedge clk) disable iff (rst)
      busReq.valid && !busRsp.ready |=> busReq.valid && $stable(busReq.addr))
      else $error("bus request changed before ready");

endmodule

/* hw/vread_ctrl.sv */
`timescale 1ns/1ps

`include "vread_macros.svh"

module vread_ctrl (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run,
   input  logic [`VREAD_SIZE_W-1:0] fetchSize,
   input  logic                     streamEmpty,
   input  logic                     fetchDone,
   input  logic                     streamDone,
   output logic                     fetchStart,
   output logic                     streamStart,
   output logic                     busy,
   output logic                     done
);

   vread_pkg::ctrlState_t state;

   assign busy = (state != vread_pkg::IDLE);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state       <= vread_pkg::IDLE;
         fetchStart  <= 1'b0;
         streamStart <= 1'b0;
         done        <= 1'b0;
      end
      else
      begin
         // start pulses and done last a single cycle
         fetchStart  <= 1'b0;
         streamStart <= 1'b0;
         done        <= 1'b0;
         case (state)
            vread_pkg::IDLE:
            begin
               if (run)
               begin
                  if (fetchSize != '0)
                  begin
                     state      <= vread_pkg::FETCH;
                     fetchStart <= 1'b1;
                  end
                  else if (!streamEmpty)
                  begin
                     state       <= vread_pkg::STREAM;
                     streamStart <= 1'b1;
                  end
                  else
                  begin
                     state <= vread_pkg::FINISH;
                  end
               end
            end
            vread_pkg::FETCH:
            begin
               if (fetchDone)
               begin
                  state       <= streamEmpty ? vread_pkg::FINISH : vread_pkg::STREAM;
                  streamStart <= !streamEmpty;
               end
            end
            vread_pkg::STREAM:
            begin
               if (streamDone)
               begin
                  state <= vread_pkg::FINISH;
               end
            end
            default:
            begin
               // one extra cycle covers the registered memory read
               state <= vread_pkg::IDLE;
               done  <= 1'b1;
            end
         endcase
      end
   end

   fetchDoneInFetch: assert property (@(posedge clk) disable iff (rst)
      fetchDone |-> state == vread_pkg::FETCH)
      else $error("fetch done outside the fetch phase");

   streamDoneInStream: assert property (@(posedge clk) disable iff (rst)
      streamDone |-> state == vread_pkg::STREAM)
      else $error("stream done outside the stream phase");

endmodule

/* hw/vread_pkg.sv */
`include "vread_macros.svh"

package vread_pkg;

   // one block fetch from external memory
   typedef struct packed {
      logic [`VREAD_IO_ADDR_W-1:0]  extAddr;
      logic [`VREAD_MEM_ADDR_W-1:0] intAddr;
      logic [`VREAD_SIZE_W-1:0]     size;
   } fetchCfg_t;

   // single loop level address generator
   typedef struct packed {
      logic [`VREAD_MEM_ADDR_W-1:0] start;
      logic [`VREAD_MEM_ADDR_W-1:0] iter;
      logic [`VREAD_PERIOD_W-1:0]   per;
      logic [`VREAD_PERIOD_W-1:0]   duty;
      logic [`VREAD_MEM_ADDR_W-1:0] incr;
      logic [`VREAD_MEM_ADDR_W-1:0] shift;
      logic                         reverse;
   } streamCfg_t;

   typedef struct packed {
      logic                        valid;
      logic [`VREAD_IO_ADDR_W-1:0] addr;
   } busReq_t;

   typedef struct packed {
      logic                     ready;
      logic [`VREAD_DATA_W-1:0] rdata;
   } busRsp_t;

   typedef struct packed {
      logic                         en;
      logic [`VREAD_MEM_ADDR_W-1:0] addr;
      logic [`VREAD_DATA_W-1:0]     data;
   } memWr_t;

   typedef struct packed {
      logic                         en;
      logic [`VREAD_MEM_ADDR_W-1:0] addr;
   } memRd_t;

   typedef enum logic [1:0] {IDLE, FETCH, STREAM, FINISH} ctrlState_t;

endpackage

/* hw/vread_macros.svh */
`ifndef VREAD_MACROS_SVH
`define VREAD_MACROS_SVH

// flow and bus data word
`define VREAD_DATA_W 32

// external word address
`define VREAD_IO_ADDR_W 32

// internal memory address, 256 words deep
`define VREAD_MEM_ADDR_W 8

// transfer length, one bit wider so 256 fits
`define VREAD_SIZE_W 9

// period and duty fields
`define VREAD_PERIOD_W 6

`endif
